//--- common/core_pkg.sv
// Core package for the register-file execution engine
// Shared vector types, command opcodes, buffer and credit sizes, FSM states
package core_pkg;

    // Data word and register index
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // Command code
    typedef logic [2:0] opcode_t;

    // Load-immediate, imm goes straight to rd
    localparam opcode_t OP_LI  = 3'd0;
    localparam opcode_t OP_ADD = 3'd1;
    localparam opcode_t OP_SUB = 3'd2;
    localparam opcode_t OP_AND = 3'd3;
    localparam opcode_t OP_OR  = 3'd4;
    localparam opcode_t OP_XOR = 3'd5;
    // Signed compare, result is 1 or 0
    localparam opcode_t OP_SLT = 3'd6;
    // Shift by rs2[4:0] only
    localparam opcode_t OP_SLL = 3'd7;

    // Command buffer depth, also the upstream credits after reset
    localparam int CMD_DEPTH = 4;

    // Downstream credits held after reset
    localparam int RES_CREDITS = 2;

    // Wide enough for either count
    typedef logic [2:0] credit_t;

    // Issue FSM states
    typedef enum logic [1:0] {
        ST_CLEAR,
        ST_RUN,
        ST_WAIT
    } issue_state_t;

endpackage

//--- common/rf_if.sv
// Register file bus
// One write port and two combinational read ports
`timescale 1ns/1ns

interface rf_if;
    import core_pkg::*;

    // Write port
    reg_idx_t rd_idx;
    word_t    rd_val;
    logic     rd_wen;

    // Read ports
    reg_idx_t rs1_idx;
    word_t    rs1_val;
    reg_idx_t rs2_idx;
    word_t    rs2_val;

    // Register file side
    modport rf (
        input  rd_idx, rd_val, rd_wen, rs1_idx, rs2_idx,
        output rs1_val, rs2_val
    );

    // Write-back side
    modport wr (output rd_idx, rd_val, rd_wen);

    // Operand fetch side
    modport rd (output rs1_idx, rs2_idx, input rs1_val, rs2_val);

endinterface

//--- common/issue_if.sv
// Issue bus
// Carries one issued command from the issue FSM to the execute stage
`timescale 1ns/1ns

interface issue_if;
    import core_pkg::*;

    // Command present this cycle
    logic     valid;
    opcode_t  op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
    // Low for the post-reset clear writes
    logic     report;

    // Issue FSM side
    modport src (output valid, op, rd, rs1, rs2, imm, report);

    // Execute stage side
    modport dst (input valid, op, rd, rs1, rs2, imm, report);

endinterface

//--- hdl/cmd_fifo.sv
// Command buffer
// Circular buffer sized to the upstream credits, returns one credit per pop
`timescale 1ns/1ns

module cmd_fifo (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              push,
    input  core_pkg::opcode_t push_op,
    input  core_pkg::reg_idx_t push_rd,
    input  core_pkg::reg_idx_t push_rs1,
    input  core_pkg::reg_idx_t push_rs2,
    input  core_pkg::word_t   push_imm,
    input  logic              pop,
    output logic              empty,
    output core_pkg::opcode_t head_op,
    output core_pkg::reg_idx_t head_rd,
    output core_pkg::reg_idx_t head_rs1,
    output core_pkg::reg_idx_t head_rs2,
    output core_pkg::word_t   head_imm,
    output logic              credit_ret
);
    import core_pkg::*;

    // Storage, one array per field
    opcode_t  op_mem  [CMD_DEPTH];
    reg_idx_t rd_mem  [CMD_DEPTH];
    reg_idx_t rs1_mem [CMD_DEPTH];
    reg_idx_t rs2_mem [CMD_DEPTH];
    word_t    imm_mem [CMD_DEPTH];

    logic [$clog2(CMD_DEPTH)-1:0] wr_ptr;
    logic [$clog2(CMD_DEPTH)-1:0] rd_ptr;
    // Entries held, 0 to CMD_DEPTH
    credit_t count;

    // Write side, upstream credits keep it from overflowing
    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr]  <= push_op;
            rd_mem[wr_ptr]  <= push_rd;
            rs1_mem[wr_ptr] <= push_rs1;
            rs2_mem[wr_ptr] <= push_rs2;
            imm_mem[wr_ptr] <= push_imm;
        end
    end

    // Pointers, occupancy and the registered credit return
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Net change when both happen
            case ({push, pop})
                2'b10:   count <= count + credit_t'(1);
                2'b01:   count <= count - credit_t'(1);
                default: count <= count;
            endcase
            credit_ret <= pop;
        end
    end

    assign empty = (count == '0);

    // Head entry read combinationally
    assign head_op  = op_mem[rd_ptr];
    assign head_rd  = rd_mem[rd_ptr];
    assign head_rs1 = rs1_mem[rd_ptr];
    assign head_rs2 = rs2_mem[rd_ptr];
    assign head_imm = imm_mem[rd_ptr];

endmodule

//--- hdl/credit_counter.sv
// Downstream credit counter
// Tracks how many results the engine may still send
`timescale 1ns/1ns

module credit_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic take,
    input  logic give,
    output logic avail
);
    import core_pkg::*;

    credit_t count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= credit_t'(RES_CREDITS);
        end else begin
            // Take and give in one cycle cancel out
            case ({take, give})
                2'b10:   count <= count - credit_t'(1);
                2'b01:   count <= count + credit_t'(1);
                default: count <= count;
            endcase
        end
    end

    // Issue allowed while any credit is left
    assign avail = (count != '0);

endmodule

//--- hdl/issue_fsm.sv
// Issue FSM
// Clears x1 to x31 after reset, then issues buffered commands against credits
`timescale 1ns/1ns

module issue_fsm (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               empty,
    input  logic               credit_avail,
    output logic               pop,
    output logic               take,
    input  core_pkg::opcode_t  head_op,
    input  core_pkg::reg_idx_t head_rd,
    input  core_pkg::reg_idx_t head_rs1,
    input  core_pkg::reg_idx_t head_rs2,
    input  core_pkg::word_t    head_imm,
    issue_if.src               iss
);
    import core_pkg::*;

    issue_state_t state;
    issue_state_t next_state;
    // Register being cleared
    reg_idx_t     clr_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_CLEAR;
            clr_idx <= reg_idx_t'(1);
        end else begin
            state <= next_state;
            if (state == ST_CLEAR) begin
                clr_idx <= clr_idx + reg_idx_t'(1);
            end
        end
    end

    always_comb begin
        next_state = state;
        pop        = 1'b0;
        // Head command by default, qualified by valid
        iss.valid  = 1'b0;
        iss.op     = head_op;
        iss.rd     = head_rd;
        iss.rs1    = head_rs1;
        iss.rs2    = head_rs2;
        iss.imm    = head_imm;
        iss.report = 1'b0;
        case (state)
            ST_CLEAR: begin
                // Silent load of zero, one register per cycle
                iss.valid = 1'b1;
                iss.op    = OP_LI;
                iss.rd    = clr_idx;
                iss.rs1   = '0;
                iss.rs2   = '0;
                iss.imm   = '0;
                if (clr_idx == '1) begin
                    next_state = ST_RUN;
                end
            end
            ST_RUN: begin
                if (!empty) begin
                    if (credit_avail) begin
                        pop        = 1'b1;
                        iss.valid  = 1'b1;
                        iss.report = 1'b1;
                    end else begin
                        // Out of downstream credits
                        next_state = ST_WAIT;
                    end
                end
            end
            ST_WAIT: begin
                if (credit_avail) begin
                    next_state = ST_RUN;
                end
            end
            default: next_state = ST_CLEAR;
        endcase
    end

    // Every real issue spends one downstream credit
    assign take = pop;

endmodule

//--- regfile/core_rf.sv
// Register file, 31 storage entries plus hard-wired x0
// Combinational reads with same-cycle write forwarding
`timescale 1ns/1ns

module core_rf (
    input logic clk,
    rf_if.rf    rf
);
    import core_pkg::*;

    // x1 to x31, x0 has no storage
    word_t regs [31:1];

    // Writes to x0 are dropped
    always_ff @(posedge clk) begin
        if (rf.rd_wen && (rf.rd_idx != '0)) begin
            regs[rf.rd_idx] <= rf.rd_val;
        end
    end

    // rs1 read port
    always_comb begin
        if (rf.rs1_idx == '0) begin
            rf.rs1_val = '0;
        end else if (rf.rd_wen && (rf.rs1_idx == rf.rd_idx)) begin
            // Forward the write in flight
            rf.rs1_val = rf.rd_val;
        end else begin
            rf.rs1_val = regs[rf.rs1_idx];
        end
    end

    // rs2 read port
    always_comb begin
        if (rf.rs2_idx == '0) begin
            rf.rs2_val = '0;
        end else if (rf.rd_wen && (rf.rs2_idx == rf.rd_idx)) begin
            // Forward the write in flight
            rf.rs2_val = rf.rd_val;
        end else begin
            rf.rs2_val = regs[rf.rs2_idx];
        end
    end

endmodule

//--- hdl/exec_stage.sv
// Execute stage
// ALU on the issued command, result register feeding write-back and results
`timescale 1ns/1ns

module exec_stage (
    input  logic               clk,
    input  logic               rst_n,
    issue_if.dst               iss,
    rf_if.wr                   rfw,
    rf_if.rd                   rfr,
    output logic               res_valid,
    output core_pkg::reg_idx_t res_rd,
    output core_pkg::word_t    res_val
);
    import core_pkg::*;

    word_t    alu_out;
    // Result register
    logic     valid_q;
    logic     report_q;
    reg_idx_t rd_q;
    word_t    res_q;

    // Operand fetch straight from the issued command
    assign rfr.rs1_idx = iss.rs1;
    assign rfr.rs2_idx = iss.rs2;

    always_comb begin
        case (iss.op)
            OP_LI:   alu_out = iss.imm;
            OP_ADD:  alu_out = rfr.rs1_val + rfr.rs2_val;
            OP_SUB:  alu_out = rfr.rs1_val - rfr.rs2_val;
            OP_AND:  alu_out = rfr.rs1_val & rfr.rs2_val;
            OP_OR:   alu_out = rfr.rs1_val | rfr.rs2_val;
            OP_XOR:  alu_out = rfr.rs1_val ^ rfr.rs2_val;
            // Signed compare, zero-extended to a word
            OP_SLT:  alu_out = word_t'($signed(rfr.rs1_val) < $signed(rfr.rs2_val));
            // Only the low 5 bits of rs2 count
            OP_SLL:  alu_out = rfr.rs1_val << rfr.rs2_val[4:0];
            default: alu_out = '0;
        endcase
    end

    // Control bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= 1'b0;
            report_q <= 1'b0;
        end else begin
            valid_q  <= iss.valid;
            report_q <= iss.valid && iss.report;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        rd_q  <= iss.rd;
        res_q <= alu_out;
    end

    // Write-back in the cycle after issue
    assign rfw.rd_wen = valid_q;
    assign rfw.rd_idx = rd_q;
    assign rfw.rd_val = res_q;

    // Clear writes stay silent
    assign res_valid = report_q;
    assign res_rd    = rd_q;
    assign res_val   = res_q;

endmodule

//--- hdl/rf_engine.sv
// Register-file execution engine top level
// Credit-controlled command input, ALU execution and credit-controlled results
`timescale 1ns/1ns

module rf_engine (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cmd_valid,
    input  core_pkg::opcode_t  cmd_op,
    input  core_pkg::reg_idx_t cmd_rd,
    input  core_pkg::reg_idx_t cmd_rs1,
    input  core_pkg::reg_idx_t cmd_rs2,
    input  core_pkg::word_t    cmd_imm,
    output logic               cmd_credit,
    output logic               res_valid,
    output core_pkg::reg_idx_t res_rd,
    output core_pkg::word_t    res_val,
    input  logic               res_credit
);
    import core_pkg::*;

    // Buffer head
    logic     empty;
    opcode_t  head_op;
    reg_idx_t head_rd;
    reg_idx_t head_rs1;
    reg_idx_t head_rs2;
    word_t    head_imm;

    // Issue handshake
    logic pop;
    logic take;
    logic credit_avail;

    rf_if    rf_bus ();
    issue_if iss_bus ();

    cmd_fifo u_cmd_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (cmd_valid),
        .push_op    (cmd_op),
        .push_rd    (cmd_rd),
        .push_rs1   (cmd_rs1),
        .push_rs2   (cmd_rs2),
        .push_imm   (cmd_imm),
        .pop        (pop),
        .empty      (empty),
        .head_op    (head_op),
        .head_rd    (head_rd),
        .head_rs1   (head_rs1),
        .head_rs2   (head_rs2),
        .head_imm   (head_imm),
        .credit_ret (cmd_credit)
    );

    credit_counter u_credit_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .take  (take),
        .give  (res_credit),
        .avail (credit_avail)
    );

    issue_fsm u_issue_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .empty        (empty),
        .credit_avail (credit_avail),
        .pop          (pop),
        .take         (take),
        .head_op      (head_op),
        .head_rd      (head_rd),
        .head_rs1     (head_rs1),
        .head_rs2     (head_rs2),
        .head_imm     (head_imm),
        .iss          (iss_bus.src)
    );

    core_rf u_core_rf (
        .clk (clk),
        .rf  (rf_bus.rf)
    );

    exec_stage u_exec_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .iss       (iss_bus.dst),
        .rfw       (rf_bus.wr),
        .rfr       (rf_bus.rd),
        .res_valid (res_valid),
        .res_rd    (res_rd),
        .res_val   (res_val)
    );

endmodule

//--- testbench/rf_engine_properties.sv
// Bound checks on the engine's credit protocol
// Reset quiet period, outstanding results and returned command credits
`timescale 1ns/1ns

module rf_engine_properties (
    input logic clk,
    input logic rst_n,
    input logic cmd_valid,
    input logic cmd_credit,
    input logic res_valid,
    input logic res_credit
);
    import core_pkg::*;

    // Results sent but not yet credited back
    int outstanding;
    // Commands taken in and credits handed back
    int accepted;
    int returned;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= 0;
            accepted    <= 0;
            returned    <= 0;
        end else begin
            outstanding <= outstanding + int'(res_valid) - int'(res_credit);
            accepted    <= accepted + int'(cmd_valid);
            returned    <= returned + int'(cmd_credit);
        end
    end

    // Nothing leaves in the first cycle out of reset
    assert property (@(posedge clk) $rose(rst_n) |-> !res_valid)
        else $error("result presented in the first cycle after reset");

    // Current result counts against the credits too
    assert property (@(posedge clk) disable iff (!rst_n)
        outstanding + int'(res_valid) <= RES_CREDITS)
        else $error("more results outstanding than downstream credits");

    assert property (@(posedge clk) disable iff (!rst_n)
        returned + int'(cmd_credit) <= accepted)
        else $error("more command credits returned than commands accepted");

endmodule

//--- testbench/rf_engine_tb.sv
// Testbench for the register-file execution engine
// File-driven commands with credit models on the command and result sides
`timescale 1ns/1ns

module rf_engine_tb;
    import core_pkg::*;

    logic     clk;
    logic     rst_n;
    logic     cmd_valid;
    opcode_t  cmd_op;
    reg_idx_t cmd_rd;
    reg_idx_t cmd_rs1;
    reg_idx_t cmd_rs2;
    word_t    cmd_imm;
    logic     cmd_credit;
    logic     res_valid;
    reg_idx_t res_rd;
    word_t    res_val;
    logic     res_credit;

    // Commands from the data file
    opcode_t  t_op  [$];
    reg_idx_t t_rd  [$];
    reg_idx_t t_rs1 [$];
    reg_idx_t t_rs2 [$];
    word_t    t_imm [$];
    // Expected results in command order
    reg_idx_t exp_rd  [$];
    word_t    exp_val [$];

    int unsigned n_tests;
    bit          loaded;
    int          up_credits;
    int          sent;
    int          checked;
    int          credits_back;
    int          cycle;
    // Cycles at which res_credit pulses are due
    int          due_q [$];
    int          last_due;
    logic [31:0] rng_state;

    rf_engine DUT (.*);

    bind rf_engine rf_engine_properties u_properties (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        if (got !== want) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, want);
            $display("=== FAIL ===");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        int          op;
        int          rd;
        int          rs1;
        int          rs2;
        int          erd;
        logic [31:0] imm;
        logic [31:0] eval;
        fd = $fopen("testbench/rf_engine_tests.txt", "r");
        if (fd == 0) begin
            $display("the test file testbench/rf_engine_tests.txt could not be opened");
            $display("=== FAIL ===");
            $fatal(1, "no stimulus");
        end
        while ($fgets(line, fd) > 0) begin
            // Comment and blank lines
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %d %d %d %h %d %h", op, rd, rs1, rs2, imm, erd, eval);
            if (n != 7) begin
                $display("a line of the test file has the wrong number of columns");
                $display("=== FAIL ===");
                $fatal(1, "bad test line");
            end
            t_op.push_back(opcode_t'(op));
            t_rd.push_back(reg_idx_t'(rd));
            t_rs1.push_back(reg_idx_t'(rs1));
            t_rs2.push_back(reg_idx_t'(rs2));
            t_imm.push_back(imm);
            exp_rd.push_back(reg_idx_t'(erd));
            exp_val.push_back(eval);
        end
        $fclose(fd);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        cmd_valid    = 1'b0;
        cmd_op       = '0;
        cmd_rd       = '0;
        cmd_rs1      = '0;
        cmd_rs2      = '0;
        cmd_imm      = '0;
        res_credit   = 1'b0;
        up_credits   = CMD_DEPTH;
        sent         = 0;
        checked      = 0;
        credits_back = 0;
        cycle        = 0;
        last_due     = 0;
        rng_state    = 32'd68574;
        load_tests();
        n_tests = t_op.size();
        loaded  = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        wait (checked == n_tests);
        // Room for the last cmd_credit pulse
        repeat (4) @(posedge clk);
        check_value(credits_back, n_tests, "cmd_credit pulse count");
        $display("=== PASS ===");
        $finish;
    end

    // Upstream and downstream models
    always @(posedge clk) begin
        logic running;
        cycle = cycle + 1;
        // Reset state as seen at the rising edge
        running = rst_n;
        #2;
        // Upstream sends only while it holds a credit
        if (running && sent < n_tests && up_credits > 0) begin
            cmd_valid  = 1'b1;
            cmd_op     = t_op[sent];
            cmd_rd     = t_rd[sent];
            cmd_rs1    = t_rs1[sent];
            cmd_rs2    = t_rs2[sent];
            cmd_imm    = t_imm[sent];
            sent       = sent + 1;
            up_credits = up_credits - 1;
        end else begin
            cmd_valid = 1'b0;
        end
        // Downstream credits go back in order
        if (due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            res_credit = 1'b1;
        end else begin
            res_credit = 1'b0;
        end
    end

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        int delay;
        int due;
        if (cmd_credit) begin
            credits_back = credits_back + 1;
            up_credits   = up_credits + 1;
        end
        if (res_valid) begin
            if (exp_val.size() == 0) begin
                $display("a result for rd %0d arrived with no command left to match", res_rd);
                $display("=== FAIL ===");
                $fatal(1, "extra result");
            end
            check_value(32'(res_rd), 32'(exp_rd.pop_front()), "res_rd");
            check_value(res_val, exp_val.pop_front(), "res_val");
            checked = checked + 1;
            // Consumed 0 to 5 cycles later
            delay = int'(xorshift32() % 6);
            due   = cycle + 1 + delay;
            // At most one credit pulse per cycle
            if (due <= last_due) begin
                due = last_due + 1;
            end
            last_due = due;
            due_q.push_back(due);
        end
    end

    // Watchdog
    initial begin
        wait (loaded);
        repeat (200 * n_tests + 100) @(posedge clk);
        $display("timeout: the engine did not deliver all results in time");
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- testbench/rf_engine_tests.txt
# op rd rs1 rs2 imm(hex) | expected rd, expected value(hex)
# op: 0 li, 1 add, 2 sub, 3 and, 4 or, 5 xor, 6 slt, 7 sll
1 3 1 2 00000000 3 00000000
4 4 31 30 00000000 4 00000000
0 0 0 0 12345678 0 12345678
1 5 0 0 00000000 5 00000000
0 1 0 0 00000007 1 00000007
0 2 0 0 fffffffb 2 fffffffb
1 3 1 2 00000000 3 00000002
2 4 1 2 00000000 4 0000000c
3 5 1 2 00000000 5 00000003
4 6 1 2 00000000 6 ffffffff
5 7 1 2 00000000 7 fffffffc
6 8 2 1 00000000 8 00000001
6 9 1 2 00000000 9 00000000
0 10 0 0 80000000 10 80000000
6 11 10 2 00000000 11 00000001
0 12 0 0 00000024 12 00000024
7 13 1 12 00000000 13 00000070
0 14 0 0 0000001f 14 0000001f
7 15 1 14 00000000 15 80000000
0 23 0 0 00000020 23 00000020
7 24 1 23 00000000 24 00000007
1 16 1 1 00000000 16 0000000e
1 16 16 1 00000000 16 00000015
2 17 16 1 00000000 17 0000000e
5 18 17 16 00000000 18 0000001b
7 18 18 12 00000000 18 000001b0
4 19 0 18 00000000 19 000001b0
1 20 0 1 00000000 20 00000007
4 21 29 28 00000000 21 00000000
6 22 2 0 00000000 22 00000001

//--- rf_engine.f
common/core_pkg.sv
common/rf_if.sv
common/issue_if.sv
hdl/cmd_fifo.sv
hdl/credit_counter.sv
hdl/issue_fsm.sv
regfile/core_rf.sv
hdl/exec_stage.sv
hdl/rf_engine.sv
testbench/rf_engine_properties.sv
testbench/rf_engine_tb.sv

//--- Bender.yml
package:
  name: rf_engine

sources:
  - common/core_pkg.sv
  - common/rf_if.sv
  - common/issue_if.sv
  - hdl/cmd_fifo.sv
  - hdl/credit_counter.sv
  - hdl/issue_fsm.sv
  - regfile/core_rf.sv
  - hdl/exec_stage.sv
  - hdl/rf_engine.sv
  - target: test
    files:
      - testbench/rf_engine_properties.sv
      - testbench/rf_engine_tb.sv
